// ==== Bender.yml ====
package:
  name: core_video

sources:
  - include_dirs:
      - .
    files:
      - verilog/pce_video_pkg.sv
      - verilog/raster_if.sv
      - verilog/settings_regs.sv
      - verilog/raster_tracker.sv
      - verilog/video_output_stage.sv
      - verilog/core_video_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - testbench/core_video_checker.sv
      - testbench/tb_core_video.sv

// ==== pce_video_cfg.svh ====
// width, address and timing constants for the video wrapper
// bridge setting addresses, expected raster sizes, sync shaping

`ifndef PCE_VIDEO_CFG_SVH
`define PCE_VIDEO_CFG_SVH

// bridge bus
`define PCE_BRIDGE_ADDR_W 32
`define PCE_BRIDGE_DATA_W 32

// setting register addresses
`define PCE_ADDR_SGX      32'h0000_0004
`define PCE_ADDR_RESET    32'h0000_0050
`define PCE_ADDR_OVERSCAN 32'h0000_0200

// core reset hold after a reset write, in clk_74a cycles
`define PCE_RESET_HOLD 1024

// expected raster size
`define PCE_WIDTH_NARROW   352
`define PCE_WIDTH_WIDE     512
`define PCE_LINES_FULL     240
`define PCE_LINES_OVERSCAN 224

// border and sync shaping
`define PCE_BORDER_HOLD   4
`define PCE_BORDER_PIXELS 24
`define PCE_HS_DELAY      6

// max line width thresholds for the scaler slot code
`define PCE_SLOT_WIDE_MIN 380
`define PCE_SLOT_352_MIN  330
`define PCE_SLOT_320_MIN  280

`endif

// ==== tb.f ====
+incdir+.
verilog/pce_video_pkg.sv
verilog/raster_if.sv
verilog/settings_regs.sv
verilog/raster_tracker.sv
verilog/video_output_stage.sv
verilog/core_video_top.sv
testbench/core_video_checker.sv
testbench/tb_core_video.sv

// ==== testbench/core_video_checker.sv ====
// concurrent assertions on the scaler syncs and reset behavior
// one cycle video_vs and video_hs, quiet outputs during reset

`timescale 1ns/1ps
`default_nettype none

module core_video_checker (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire video_vs,
  input wire video_hs,
  input wire video_de,
  input wire core_reset
);

  // vsync is a single cycle strobe
  a_vs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs
  ) else $error("video_vs stayed high for two cycles");

  // delayed hsync is a single cycle strobe
  a_hs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs
  ) else $error("video_hs stayed high for two cycles");

  // nothing reaches the scaler or the core while the pll is unlocked
  a_reset_quiet: assert property (
    @(posedge clk_74a)
    !pll_core_locked |-> (!video_de && !core_reset)
  ) else $error("video_de or core_reset active during reset");

endmodule

bind core_video_top core_video_checker core_video_checker_inst (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .video_vs       (video_vs),
  .video_hs       (video_hs),
  .video_de       (video_de),
  .core_reset     (core_reset)
);

`default_nettype wire

// ==== testbench/tb_core_video.sv ====
// testbench for the video wrapper top level
// clock, reset, raster drivers, output monitor, directed tests, watchdog

`timescale 1ns/1ps
`default_nettype none

`include "pce_video_cfg.svh"

module tb_core_video
  import pce_video_pkg::*;
();

  localparam int LINE_NARROW = 400;
  localparam int LINE_WIDE   = 600;
  // frame = 20 vsync cycles plus active lines plus two blank lines
  localparam int WATCHDOG_CYCLES =
    (20 + 8 * LINE_NARROW) + (20 + 8 * LINE_WIDE) + 2 * (20 + 252 * LINE_NARROW) +
    (20 + 6 * LINE_WIDE) + 4 * (20 + 5 * LINE_WIDE) + 2 * `PCE_RESET_HOLD + 5000;

  logic           clk_74a;
  logic           pll_core_locked;
  logic           bridge_wr;
  bridge_addr_t   bridge_addr;
  bridge_data_t   bridge_wr_data;
  logic           hblank;
  logic           vblank;
  logic           core_hs;
  logic           core_vs;
  logic           border;
  rgb_t           core_rgb;
  dotclock_mode_t dotclock_mode;
  logic           core_reset;
  logic           sgx;
  rgb_t           video_rgb;
  logic           video_de;
  logic           video_hs;
  logic           video_vs;

  // driver and monitor state
  int           line_len;
  int           exp_width;
  int           de_lines;
  int           vs_seen;
  int           hs_seen;
  int           vs_driven;
  int           hs_driven;
  logic         pix_expect;
  logic         de_prev;
  logic         vs_prev_s;
  logic         hs_prev_s;
  logic [6:0]   hs_hist;
  pixel_count_t run_len;
  rgb_t         slot_word;
  int unsigned  lcg_state;

  core_video_top core_video_top_inst (.*);

  initial begin
    clk_74a = 1'b0;
    forever #50 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %06h expected %06h", what, got, exp));
    end
  endtask

  task automatic check_count(input pixel_count_t got, input pixel_count_t exp,
                             input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_line(input line_count_t got, input line_count_t exp,
                            input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_fail($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
  endfunction

  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    @(negedge clk_74a);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
    bridge_addr    = '0;
    bridge_wr_data = '0;
  endtask

  // hsync at the start, border in the back porch, active window from cycle 20
  task automatic drive_line(input int active, input bit border_line);
    int c;
    hs_driven++;
    for (c = 0; c < line_len; c++) begin
      @(negedge clk_74a);
      core_hs    = (c < 8);
      border     = border_line && (c >= 12) && (c < 20);
      hblank     = !((active > 0) && (c >= 20) && (c < 20 + active));
      core_rgb   = hblank ? '0 : rgb_t'(lcg_next());
      pix_expect = !hblank && !border_line;
    end
    pix_expect = 1'b0;
  endtask

  // active of zero picks a random width per line
  task automatic drive_frame(input int lines, input int active);
    int l;
    vblank = 1'b1;
    vs_driven++;
    for (l = 0; l < 20; l++) begin
      @(negedge clk_74a);
      core_vs = (l < 4);
    end
    vblank = 1'b0;
    for (l = 0; l < lines; l++) begin
      drive_line((active == 0) ? rand_range(250, 340) : active, l == 1);
    end
    vblank = 1'b1;
    drive_line(0, 1'b0);
    drive_line(0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor sampled well after the falling edge drive

  always @(negedge clk_74a) begin
    #20;
    if (!pll_core_locked) begin
      hs_hist   = '0;
      de_prev   = 1'b0;
      run_len   = '0;
      vs_prev_s = 1'b0;
      hs_prev_s = 1'b0;
    end else begin
      hs_hist = {hs_hist[5:0], core_hs && !hs_prev_s};
      check_bit(video_vs, core_vs && !vs_prev_s, "video_vs");
      check_bit(video_hs, hs_hist[6], "video_hs");
      vs_seen += video_vs;
      hs_seen += video_hs;
      if (pix_expect) begin
        check_rgb(video_rgb, core_rgb, "pixel inside core DE");
      end
      if (video_de) begin
        run_len++;
        if (!de_prev) begin
          de_lines++;
        end
      end else if (de_prev) begin
        slot_word = video_rgb;
        if (exp_width != 0) begin
          check_count(run_len, pixel_count_t'(exp_width), "video_de cycles per line");
        end
        run_len = '0;
      end
      de_prev   = video_de;
      vs_prev_s = core_vs;
      hs_prev_s = core_hs;
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic line_padding_test();
    dotclock_mode = DOT_352;
    line_len      = LINE_NARROW;
    exp_width     = `PCE_WIDTH_NARROW;
    de_lines      = 0;
    drive_frame(6, 0);
    check_line(line_count_t'(de_lines), 9'd6, "DE lines in narrow frame");
    dotclock_mode = DOT_512_A;
    line_len      = LINE_WIDE;
    exp_width     = `PCE_WIDTH_WIDE;
    de_lines      = 0;
    drive_frame(6, 0);
    check_line(line_count_t'(de_lines), 9'd6, "DE lines in wide frame");
  endtask

  task automatic line_count_test();
    dotclock_mode = DOT_352;
    line_len      = LINE_NARROW;
    exp_width     = `PCE_WIDTH_NARROW;
    bridge_write(`PCE_ADDR_OVERSCAN, 32'd0);
    de_lines = 0;
    drive_frame(250, 0);
    check_line(line_count_t'(de_lines), `PCE_LINES_FULL, "DE lines without overscan");
    bridge_write(`PCE_ADDR_OVERSCAN, 32'd1);
    de_lines = 0;
    drive_frame(250, 0);
    check_line(line_count_t'(de_lines), `PCE_LINES_OVERSCAN, "DE lines with overscan");
  endtask

  task automatic sync_shaping_test();
    dotclock_mode = DOT_512_A;
    line_len      = LINE_WIDE;
    exp_width     = `PCE_WIDTH_WIDE;
    vs_seen   = 0;
    hs_seen   = 0;
    vs_driven = 0;
    hs_driven = 0;
    drive_frame(4, 320);
    check_cycles(vs_seen, vs_driven, "video_vs pulses");
    check_cycles(hs_seen, hs_driven, "video_hs pulses");
  endtask

  task automatic slot_frame(input int active, input video_slot_t code, input logic ovs);
    drive_frame(3, active);
    check_rgb(slot_word, {8'h00, code, ovs, 13'h0000}, "slot word");
  endtask

  task automatic slot_word_test();
    dotclock_mode = DOT_512_A;
    line_len      = LINE_WIDE;
    exp_width     = `PCE_WIDTH_WIDE;
    bridge_write(`PCE_ADDR_OVERSCAN, 32'd1);
    slot_frame(300, 2'd1, 1'b1);
    slot_frame(340, 2'd2, 1'b1);
    slot_frame(400, 2'd0, 1'b1);
    bridge_write(`PCE_ADDR_OVERSCAN, 32'd0);
    slot_frame(340, 2'd2, 1'b0);
  endtask

  task automatic settings_test();
    int high;
    int n;
    high = 0;
    bridge_write(`PCE_ADDR_SGX, 32'd1);
    #20;
    check_bit(sgx, 1'b1, "sgx after write of 1");
    bridge_write(`PCE_ADDR_SGX, 32'd0);
    #20;
    check_bit(sgx, 1'b0, "sgx after write of 0");
    bridge_write(`PCE_ADDR_RESET, 32'd1);
    #20;
    check_bit(core_reset, 1'b1, "core_reset on the cycle after the write");
    // count the hold over twice its length
    for (n = 0; n < 2 * `PCE_RESET_HOLD; n++) begin
      if (core_reset) begin
        high++;
      end
      @(negedge clk_74a);
      #20;
    end
    check_cycles(high, `PCE_RESET_HOLD, "core_reset hold cycles");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    pll_core_locked = 1'b0;
    bridge_wr       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    hblank          = 1'b1;
    vblank          = 1'b1;
    core_hs         = 1'b0;
    core_vs         = 1'b0;
    border          = 1'b0;
    core_rgb        = '0;
    dotclock_mode   = DOT_256;
    pix_expect      = 1'b0;
    lcg_state       = 77;
    line_len        = LINE_WIDE;
    exp_width       = 0;
    de_lines        = 0;
    vs_seen         = 0;
    hs_seen         = 0;
    vs_driven       = 0;
    hs_driven       = 0;
    slot_word       = '0;
    // four rising edges in reset, released on the falling edge after them
    repeat (4) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;
    #20;
    check_bit(core_reset, 1'b0, "core_reset after reset");
    check_bit(sgx, 1'b0, "sgx after reset");
    check_bit(video_de, 1'b0, "video_de after reset");
    line_padding_test();
    line_count_test();
    sync_shaping_test();
    slot_word_test();
    settings_test();
    $display("Regression passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_74a);
    $display("Watchdog expired at %0t ns, the tests did not finish", $time);
    $display("Regression failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== verilog/core_video_top.sv ====
// video side of the core wrapper
// settings bank, raster tracker and scaler output stage

`timescale 1ns/1ps
`default_nettype none

module core_video_top
  import pce_video_pkg::*;
(
  input  wire            clk_74a,
  input  wire            pll_core_locked,

  // bridge writes
  input  wire            bridge_wr,
  input  bridge_addr_t   bridge_addr,
  input  bridge_data_t   bridge_wr_data,

  // emulated console raster
  input  wire            hblank,
  input  wire            vblank,
  input  wire            core_hs,
  input  wire            core_vs,
  input  wire            border,
  input  rgb_t           core_rgb,
  input  dotclock_mode_t dotclock_mode,

  // to the core
  output logic           core_reset,
  output logic           sgx,

  // to the scaler
  output rgb_t           video_rgb,
  output logic           video_de,
  output logic           video_hs,
  output logic           video_vs
);

  logic overscan_enable;
  logic de_expanded;

  raster_if rast ();

  ////////////////////////////////////////////////////////////
  // settings

  settings_regs settings_regs_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .sgx            (sgx),
    .overscan_enable(overscan_enable),
    .core_reset     (core_reset)
  );

  ////////////////////////////////////////////////////////////
  // raster path

  raster_tracker raster_tracker_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .hblank         (hblank),
    .vblank         (vblank),
    .core_hs        (core_hs),
    .core_vs        (core_vs),
    .border         (border),
    .de_expanded    (de_expanded),
    .rast           (rast.tracker)
  );

  video_output_stage video_output_stage_inst (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rast           (rast.stage),
    .core_rgb       (core_rgb),
    .dotclock_mode  (dotclock_mode),
    .overscan_enable(overscan_enable),
    .de_expanded    (de_expanded),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

`default_nettype wire

// ==== verilog/pce_video_pkg.sv ====
// shared types for the video wrapper
// pixel, counter and bridge word typedefs, dotclock divider enum

`default_nettype none

`include "pce_video_cfg.svh"

package pce_video_pkg;

  // 8 bits each of r, g, b
  typedef logic [23:0] rgb_t;

  // pixels within a line, wide enough for the full 512 mode line
  typedef logic [9:0] pixel_count_t;

  // lines within a frame
  typedef logic [8:0] line_count_t;

  // scaler video mode slot code
  typedef logic [1:0] video_slot_t;

  // bridge bus words
  typedef logic [`PCE_BRIDGE_ADDR_W-1:0] bridge_addr_t;
  typedef logic [`PCE_BRIDGE_DATA_W-1:0] bridge_data_t;

  // core dotclock divider setting
  // 256 and both 512 encodings share the same line width on the scaler
  typedef enum logic [1:0] {
    DOT_256   = 2'b00,
    DOT_352   = 2'b01,
    DOT_512_A = 2'b10,
    DOT_512_B = 2'b11
  } dotclock_mode_t;

endpackage

`default_nettype wire

// ==== verilog/raster_if.sv ====
// raster state bundle from the tracker to the output stage
// edge strobes, counters, line and frame progress flags

`timescale 1ns/1ps
`default_nettype none

interface raster_if
  import pce_video_pkg::*;
();

  // core blanking levels, passed on for blank extension
  logic         hblank;
  logic         vblank;

  // core DE with the border hold applied
  logic         core_de;

  // single cycle rise strobes
  logic         hs_rise;
  logic         vs_rise;

  pixel_count_t pixel_count;
  pixel_count_t max_pixel_count;
  line_count_t  line_count;

  logic         line_started;
  logic         frame_started;
  logic         border_active;

  modport tracker (
    output hblank, vblank, core_de, hs_rise, vs_rise,
    output pixel_count, max_pixel_count, line_count,
    output line_started, frame_started, border_active
  );

  modport stage (
    input hblank, vblank, core_de, hs_rise, vs_rise,
    input pixel_count, max_pixel_count, line_count,
    input line_started, frame_started, border_active
  );

endinterface

`default_nettype wire

// ==== verilog/raster_tracker.sv ====
// raster tracker for the emulated console video
// sync edge detection, border hold, pixel, line and max width counters

`timescale 1ns/1ps
`default_nettype none

`include "pce_video_cfg.svh"

module raster_tracker
  import pce_video_pkg::*;
(
  input  wire clk_74a,
  input  wire pll_core_locked,
  input  wire hblank,
  input  wire vblank,
  input  wire core_hs,
  input  wire core_vs,
  input  wire border,
  input  wire de_expanded,
  raster_if.tracker rast
);

  localparam int BORDER_W = $clog2(`PCE_BORDER_HOLD + 1);

  logic                hs_prev;
  logic                vs_prev;
  logic                core_de_prev;
  logic                de_expanded_prev;
  logic [BORDER_W-1:0] border_hold;

  logic core_de_fall;
  logic line_done;

  ////////////////////////////////////////////////////////////
  // combinational strobes

  assign rast.hblank        = hblank;
  assign rast.vblank        = vblank;
  assign rast.border_active = (border_hold != '0);

  // border drops a few pixels early, so the hold keeps DE off
  assign rast.core_de = ~hblank && ~vblank && ~rast.border_active;

  assign rast.hs_rise = core_hs && ~hs_prev;
  assign rast.vs_rise = core_vs && ~vs_prev;

  assign core_de_fall = ~rast.core_de && core_de_prev;

  // padded line has ended and the core is not drawing
  assign line_done = de_expanded_prev && ~de_expanded && ~rast.core_de;

  ////////////////////////////////////////////////////////////
  // sample history and border hold

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev          <= 1'b0;
      vs_prev          <= 1'b0;
      core_de_prev     <= 1'b0;
      de_expanded_prev <= 1'b0;
      border_hold      <= '0;
    end else begin
      hs_prev          <= core_hs;
      vs_prev          <= core_vs;
      core_de_prev     <= rast.core_de;
      de_expanded_prev <= de_expanded;

      if (border) begin
        border_hold <= BORDER_W'(`PCE_BORDER_HOLD);
      end else if (border_hold != '0) begin
        border_hold <= border_hold - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pixel and line counters

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rast.pixel_count     <= '0;
      rast.max_pixel_count <= '0;
      rast.line_count      <= '0;
      rast.line_started    <= 1'b0;
      rast.frame_started   <= 1'b0;
    end else begin
      if (rast.vs_rise) begin
        rast.line_count    <= '0;
        rast.frame_started <= 1'b0;
      end

      if (rast.hs_rise) begin
        rast.pixel_count     <= '0;
        rast.line_started    <= 1'b0;
        rast.max_pixel_count <= '0;
        // lines only count once the frame has drawn something
        if (rast.frame_started) begin
          rast.line_count <= rast.line_count + 1'b1;
        end
      end else if (rast.core_de || rast.line_started) begin
        rast.pixel_count   <= rast.pixel_count + 1'b1;
        rast.line_started  <= ~line_done;
        rast.frame_started <= 1'b1;
      end

      // widest drawn line picks the scaler slot
      if (core_de_fall && (rast.pixel_count > rast.max_pixel_count)) begin
        rast.max_pixel_count <= rast.pixel_count;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/settings_regs.sv ====
// bridge setting registers
// sgx and overscan flags, core reset hold counter

`timescale 1ns/1ps
`default_nettype none

`include "pce_video_cfg.svh"

module settings_regs
  import pce_video_pkg::*;
(
  input  wire          clk_74a,
  input  wire          pll_core_locked,
  input  wire          bridge_wr,
  input  bridge_addr_t bridge_addr,
  input  bridge_data_t bridge_wr_data,
  output logic         sgx,
  output logic         overscan_enable,
  output logic         core_reset
);

  localparam int HOLD_W = $clog2(`PCE_RESET_HOLD + 1);

  logic [HOLD_W-1:0] reset_hold;

  logic wr_sgx;
  logic wr_overscan;
  logic wr_reset;

  // exact address match, no aliasing
  assign wr_sgx      = bridge_wr && (bridge_addr == `PCE_ADDR_SGX);
  assign wr_overscan = bridge_wr && (bridge_addr == `PCE_ADDR_OVERSCAN);
  assign wr_reset    = bridge_wr && (bridge_addr == `PCE_ADDR_RESET);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      sgx             <= 1'b0;
      overscan_enable <= 1'b0;
    end else begin
      if (wr_sgx) begin
        sgx <= bridge_wr_data[0];
      end
      if (wr_overscan) begin
        overscan_enable <= bridge_wr_data[0];
      end
    end
  end

  // a new reset write restarts the hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_hold <= '0;
    end else if (wr_reset) begin
      reset_hold <= HOLD_W'(`PCE_RESET_HOLD);
    end else if (reset_hold != '0) begin
      reset_hold <= reset_hold - 1'b1;
    end
  end

  assign core_reset = (reset_hold != '0);

endmodule

`default_nettype wire

// ==== verilog/video_output_stage.sv ====
// scaler output stage
// expanded DE, one cycle vsync, delayed hsync, end of line slot word

`timescale 1ns/1ps
`default_nettype none

`include "pce_video_cfg.svh"

module video_output_stage
  import pce_video_pkg::*;
(
  input  wire            clk_74a,
  input  wire            pll_core_locked,
  raster_if.stage        rast,
  input  rgb_t           core_rgb,
  input  dotclock_mode_t dotclock_mode,
  input  wire            overscan_enable,
  output logic           de_expanded,
  output rgb_t           video_rgb,
  output logic           video_de,
  output logic           video_hs,
  output logic           video_vs
);

  localparam int HS_W = $clog2(`PCE_HS_DELAY + 1);

  logic [HS_W-1:0] hs_delay;
  logic            de_expanded_prev;

  pixel_count_t expected_width;
  line_count_t  expected_lines;
  video_slot_t  video_slot;
  rgb_t         slot_rgb;

  logic expanded_hblank;
  logic expanded_vblank;
  logic expanded_border;

  // 256 mode is pixel doubled, so it shares the 512 width
  assign expected_width = (dotclock_mode == DOT_352) ? pixel_count_t'(`PCE_WIDTH_NARROW) :
                                                       pixel_count_t'(`PCE_WIDTH_WIDE);
  assign expected_lines = overscan_enable ? line_count_t'(`PCE_LINES_OVERSCAN) :
                                            line_count_t'(`PCE_LINES_FULL);

  ////////////////////////////////////////////////////////////
  // expanded DE

  // short lines and frames keep DE up until the full size is reached
  assign expanded_hblank = rast.hblank &&
                           ~(rast.line_started && rast.pixel_count < expected_width);
  assign expanded_vblank = rast.vblank &&
                           ~(rast.frame_started && rast.line_count < line_count_t'(`PCE_LINES_FULL));
  assign expanded_border = rast.border_active &&
                           (rast.pixel_count < pixel_count_t'(`PCE_BORDER_PIXELS));

  assign de_expanded = ~expanded_hblank && ~expanded_vblank && ~expanded_border &&
                       (rast.pixel_count < expected_width) &&
                       (rast.line_count < expected_lines);

  ////////////////////////////////////////////////////////////
  // slot word and outputs

  always_comb begin
    if (rast.max_pixel_count > pixel_count_t'(`PCE_SLOT_WIDE_MIN)) begin
      video_slot = 2'd0;
    end else if (rast.max_pixel_count > pixel_count_t'(`PCE_SLOT_352_MIN)) begin
      video_slot = 2'd2;
    end else if (rast.max_pixel_count > pixel_count_t'(`PCE_SLOT_320_MIN)) begin
      video_slot = 2'd1;
    end else begin
      video_slot = 2'd0;
    end
  end

  assign slot_rgb = {8'h00, video_slot, overscan_enable, 13'h0000};

  // the slot word goes out on the first cycle after DE drops
  assign video_rgb = rast.core_de ? core_rgb :
                     (de_expanded_prev && ~de_expanded) ? slot_rgb : '0;
  assign video_de  = de_expanded;
  assign video_vs  = rast.vs_rise;
  assign video_hs  = (hs_delay == HS_W'(1));

  // hsync is pushed back so it never lands on the vsync cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_delay         <= '0;
      de_expanded_prev <= 1'b0;
    end else begin
      if (rast.hs_rise) begin
        hs_delay <= HS_W'(`PCE_HS_DELAY);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
      de_expanded_prev <= de_expanded;
    end
  end

endmodule

`default_nettype wire
